//--- fas_defines.svh
`ifndef FAS_DEFINES_SVH
`define FAS_DEFINES_SVH

// Input sample and FIR output width
`define FAS_SAMPLE_W 16

// FIR filter
`define FAS_TAPS 32
`define FAS_COEF_W 20      // Signed, 16 fraction bits

// Accepted samples before the FIR output counts
`define FAS_WARMUP 33
`define FAS_WARM_CNT_W 6   // Holds 0 to FAS_WARMUP

// FFT
`define FAS_FFT_N 16
`define FAS_BIN_IDX_W 4

// One real or imaginary part inside the butterflies
`define FAS_WORD_W 32

// Twiddle part, signed Q16
`define FAS_TW_W 32

`endif

//--- fas_pkg.sv
`include "fas_defines.svh"

package fas_pkg;

    typedef struct packed {
        logic signed [`FAS_SAMPLE_W-1:0] re;
        logic signed [`FAS_SAMPLE_W-1:0] im;
    } cplx_t;

    typedef struct packed {
        logic signed [`FAS_WORD_W-1:0] re;
        logic signed [`FAS_WORD_W-1:0] im;
    } wide_cplx_t;

    typedef struct packed {
        logic signed [`FAS_TW_W-1:0] re;
        logic signed [`FAS_TW_W-1:0] im;
    } twiddle_t;

    // One state per FFT stage load, then one output cycle
    typedef enum logic [2:0] {PH_IDLE, PH_ST1, PH_ST2, PH_ST3, PH_ST4, PH_OUT} fft_phase_e;

    // Symmetric low-pass taps
    localparam logic signed [`FAS_COEF_W-1:0] FIR_COEF [`FAS_TAPS] = '{
        20'hFFF9E, 20'hFFF86, 20'hFFFA7, 20'h0003B, 20'h0014B, 20'h0024A, 20'h00222, 20'hFFFE4,
        20'hFFBC5, 20'hFF7CA, 20'hFF74E, 20'hFFD74, 20'h00B1A, 20'h01DAC, 20'h02F9E, 20'h03AA9,
        20'h03AA9, 20'h02F9E, 20'h01DAC, 20'h00B1A, 20'hFFD74, 20'hFF74E, 20'hFF7CA, 20'hFFBC5,
        20'hFFFE4, 20'h00222, 20'h0024A, 20'h0014B, 20'h0003B, 20'hFFFA7, 20'hFFF86, 20'hFFF9E
    };

    // W_k = cos(2 pi k / 16) - j sin(2 pi k / 16)
    localparam twiddle_t TWIDDLE [`FAS_FFT_N/2] = '{
        '{32'h00010000, 32'h00000000},
        '{32'h0000EC83, 32'hFFFF9E09},
        '{32'h0000B504, 32'hFFFF4AFC},
        '{32'h000061F7, 32'hFFFF137D},
        '{32'h00000000, 32'hFFFF0000},
        '{32'hFFFF9E09, 32'hFFFF137D},
        '{32'hFFFF4AFC, 32'hFFFF4AFC},
        '{32'hFFFF137D, 32'hFFFF9E09}
    };

endpackage

//--- fir_filter.sv
`timescale 1ns/1ps
`include "fas_defines.svh"

module fir_filter (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            data_valid,
    input  logic signed [`FAS_SAMPLE_W-1:0] data,
    output logic                            fir_valid,
    output logic signed [`FAS_SAMPLE_W-1:0] fir_d
);

    logic signed [`FAS_SAMPLE_W-1:0] taps [`FAS_TAPS];   // taps[0] is the newest sample
    logic [`FAS_WARM_CNT_W-1:0]      warm_cnt;

    logic signed [`FAS_SAMPLE_W:0] pre_sum [`FAS_TAPS/2]; // Mirrored tap pairs
    logic signed [36:0]            prod [`FAS_TAPS/2];    // 17 x 20 bit
    logic signed [37:0]            sum_1 [8];
    logic signed [38:0]            sum_2 [4];
    logic signed [39:0]            sum_3 [2];
    logic signed [40:0]            acc;

    always_ff @(posedge clk)
    begin
        if (data_valid)
        begin
            taps[0] <= data;
            for (int i = 1; i < `FAS_TAPS; i++)
            begin
                taps[i] <= taps[i-1];
            end
        end
    end

    // Counts accepted samples and stops once the line is full
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            warm_cnt <= '0;
        end
        else if (data_valid && warm_cnt != `FAS_WARM_CNT_W'(`FAS_WARMUP))
        begin
            warm_cnt <= warm_cnt + `FAS_WARM_CNT_W'(1);
        end
    end

    // The coefficients mirror, so each pair shares one multiplier
    always_comb
    begin
        for (int k = 0; k < `FAS_TAPS/2; k++)
        begin
            pre_sum[k] = taps[k] + taps[`FAS_TAPS-1-k];
            prod[k]    = pre_sum[k] * fas_pkg::FIR_COEF[k];
        end
    end

    always_comb
    begin
        for (int k = 0; k < 8; k++)
        begin
            sum_1[k] = prod[2*k] + prod[2*k+1];
        end
        for (int k = 0; k < 4; k++)
        begin
            sum_2[k] = sum_1[2*k] + sum_1[2*k+1];
        end
        for (int k = 0; k < 2; k++)
        begin
            sum_3[k] = sum_2[2*k] + sum_2[2*k+1];
        end
        acc = sum_3[0] + sum_3[1];
    end

    assign fir_valid = data_valid && (warm_cnt == `FAS_WARM_CNT_W'(`FAS_WARMUP));

    // Drop 16 fraction bits, negative results get one added
    assign fir_d = {acc[40], acc[30:16]} + `FAS_SAMPLE_W'(acc[40]);

endmodule

//--- fft_butterfly.sv
`timescale 1ns/1ps
`include "fas_defines.svh"

module fft_butterfly (
    input  fas_pkg::wide_cplx_t x,
    input  fas_pkg::wide_cplx_t y,
    input  fas_pkg::twiddle_t   w,
    output fas_pkg::wide_cplx_t a,
    output fas_pkg::wide_cplx_t b
);

    logic signed [`FAS_WORD_W:0] sum_re;
    logic signed [`FAS_WORD_W:0] sum_im;
    logic signed [`FAS_WORD_W:0] dif_re;
    logic signed [`FAS_WORD_W:0] dif_im;

    // Full product of a 33-bit difference and a Q16 twiddle
    logic signed [`FAS_WORD_W+`FAS_TW_W:0] rot_re;
    logic signed [`FAS_WORD_W+`FAS_TW_W:0] rot_im;

    assign sum_re = x.re + y.re;
    assign sum_im = x.im + y.im;
    assign dif_re = x.re - y.re;
    assign dif_im = x.im - y.im;

    // Complex multiply (dr + j di)(wr + j wi)
    assign rot_re = dif_re * w.re - dif_im * w.im;
    assign rot_im = dif_re * w.im + dif_im * w.re;

    // Sum keeps its sign and drops the guard bit
    assign a.re = {sum_re[`FAS_WORD_W], sum_re[`FAS_WORD_W-2:0]};
    assign a.im = {sum_im[`FAS_WORD_W], sum_im[`FAS_WORD_W-2:0]};

    // Shift out the Q16 fraction
    assign b.re = {rot_re[`FAS_WORD_W+`FAS_TW_W], rot_re[46:16]};
    assign b.im = {rot_im[`FAS_WORD_W+`FAS_TW_W], rot_im[46:16]};

endmodule

//--- fft_engine.sv
`timescale 1ns/1ps
`include "fas_defines.svh"

module fft_engine (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  fir_valid,
    input  logic signed [`FAS_SAMPLE_W-1:0]       fir_d,
    output logic                                  fft_valid,
    output fas_pkg::cplx_t [`FAS_FFT_N-1:0]       fft_bins
);

    logic signed [`FAS_SAMPLE_W-1:0] frame_buf [`FAS_FFT_N];   // Entry 0 is the oldest
    logic [`FAS_BIN_IDX_W-1:0]       frame_cnt;
    logic                            frame_done;
    fas_pkg::fft_phase_e             phase;

    fas_pkg::wide_cplx_t op_x [`FAS_FFT_N/2];
    fas_pkg::wide_cplx_t op_y [`FAS_FFT_N/2];
    fas_pkg::twiddle_t   op_w [`FAS_FFT_N/2];
    fas_pkg::wide_cplx_t nx_x [`FAS_FFT_N/2];
    fas_pkg::wide_cplx_t nx_y [`FAS_FFT_N/2];
    fas_pkg::twiddle_t   nx_w [`FAS_FFT_N/2];
    fas_pkg::wide_cplx_t bf_a [`FAS_FFT_N/2];
    fas_pkg::wide_cplx_t bf_b [`FAS_FFT_N/2];

    // Real sample times 256, imaginary part zero
    function automatic fas_pkg::wide_cplx_t widen(input logic signed [`FAS_SAMPLE_W-1:0] s);
        fas_pkg::wide_cplx_t v;
        v.re = {{8{s[`FAS_SAMPLE_W-1]}}, s, 8'd0};
        v.im = '0;
        return v;
    endfunction

    function automatic fas_pkg::cplx_t narrow(input fas_pkg::wide_cplx_t v);
        fas_pkg::cplx_t c;
        c.re = v.re[23:8];
        c.im = v.im[23:8];
        return c;
    endfunction

    function automatic logic [`FAS_BIN_IDX_W-1:0] bit_rev(input logic [`FAS_BIN_IDX_W-1:0] v);
        return {v[0], v[1], v[2], v[3]};
    endfunction

    always_ff @(posedge clk)
    begin
        if (fir_valid)
        begin
            frame_buf[`FAS_FFT_N-1] <= fir_d;
            for (int i = 1; i < `FAS_FFT_N; i++)
            begin
                frame_buf[i-1] <= frame_buf[i];
            end
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            frame_cnt <= '0;
        end
        else if (fir_valid)
        begin
            frame_cnt <= frame_cnt + `FAS_BIN_IDX_W'(1);
        end
    end

    assign frame_done = fir_valid && (frame_cnt == '1);   // 16th sample of the frame

    // One stage per clock after the frame completes
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            phase <= fas_pkg::PH_IDLE;
        end
        else
        begin
            case (phase)
                fas_pkg::PH_IDLE: phase <= frame_done ? fas_pkg::PH_ST1 : fas_pkg::PH_IDLE;
                fas_pkg::PH_ST1:  phase <= fas_pkg::PH_ST2;
                fas_pkg::PH_ST2:  phase <= fas_pkg::PH_ST3;
                fas_pkg::PH_ST3:  phase <= fas_pkg::PH_ST4;
                fas_pkg::PH_ST4:  phase <= fas_pkg::PH_OUT;
                default:          phase <= frame_done ? fas_pkg::PH_ST1 : fas_pkg::PH_IDLE;
            endcase
        end
    end

    // Operand routing for the stage loaded at the next edge
    always_comb
    begin
        int g;
        int base;
        for (int k = 0; k < `FAS_FFT_N/2; k++)
        begin
            case (phase)
                fas_pkg::PH_ST2:
                begin
                    nx_x[k] = (k < 4) ? bf_a[k]     : bf_b[k-4];   // Distance 4
                    nx_y[k] = (k < 4) ? bf_a[k+4]   : bf_b[k];
                    nx_w[k] = fas_pkg::TWIDDLE[(2*k) % (`FAS_FFT_N/2)];
                end
                fas_pkg::PH_ST3:
                begin
                    g       = k / 2;
                    base    = (g >= 2) ? 4 + k % 2 : k % 2;     // Distance 2
                    nx_x[k] = (g % 2 == 1) ? bf_b[base]   : bf_a[base];
                    nx_y[k] = (g % 2 == 1) ? bf_b[base+2] : bf_a[base+2];
                    nx_w[k] = fas_pkg::TWIDDLE[4 * (k % 2)];
                end
                fas_pkg::PH_ST4:
                begin
                    base    = k - k % 2;                        // Distance 1
                    nx_x[k] = (k % 2 == 1) ? bf_b[base]   : bf_a[base];
                    nx_y[k] = (k % 2 == 1) ? bf_b[base+1] : bf_a[base+1];
                    nx_w[k] = fas_pkg::TWIDDLE[0];
                end
                default:
                begin
                    nx_x[k] = widen(frame_buf[k]);              // Distance 8 from the buffer
                    nx_y[k] = widen(frame_buf[k+`FAS_FFT_N/2]);
                    nx_w[k] = fas_pkg::TWIDDLE[k];
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (phase inside {fas_pkg::PH_ST1, fas_pkg::PH_ST2, fas_pkg::PH_ST3, fas_pkg::PH_ST4})
        begin
            op_x <= nx_x;
            op_y <= nx_y;
            op_w <= nx_w;
        end
    end

    for (genvar j = 0; j < `FAS_FFT_N/2; j++)
    begin : g_bfly
        fft_butterfly u_fft_butterfly (
            .x (op_x[j]),
            .y (op_y[j]),
            .w (op_w[j]),
            .a (bf_a[j]),
            .b (bf_b[j])
        );
    end

    // Last stage leaves the bins in bit-reversed order
    always_comb
    begin
        for (int j = 0; j < `FAS_FFT_N/2; j++)
        begin
            fft_bins[bit_rev(`FAS_BIN_IDX_W'(2*j))]   = narrow(bf_a[j]);
            fft_bins[bit_rev(`FAS_BIN_IDX_W'(2*j+1))] = narrow(bf_b[j]);
        end
    end

    assign fft_valid = (phase == fas_pkg::PH_OUT);

endmodule

//--- peak_bin_finder.sv
`timescale 1ns/1ps
`include "fas_defines.svh"

module peak_bin_finder (
    input  fas_pkg::cplx_t [`FAS_FFT_N-1:0] fft_bins,
    output logic [`FAS_BIN_IDX_W-1:0]       freq
);

    // Energy travels with the bin it came from
    typedef struct packed {
        logic [2*`FAS_SAMPLE_W:0]  mag;
        logic [`FAS_BIN_IDX_W-1:0] idx;
    } cand_t;

    cand_t lvl_0 [`FAS_FFT_N];
    cand_t lvl_1 [8];
    cand_t lvl_2 [4];
    cand_t lvl_3 [2];
    cand_t peak;

    // Left operand always holds the lower index, so ties keep it
    function automatic cand_t pick(input cand_t lo, input cand_t hi);
        return (lo.mag >= hi.mag) ? lo : hi;
    endfunction

    always_comb
    begin
        for (int k = 0; k < `FAS_FFT_N; k++)
        begin
            lvl_0[k].mag = fft_bins[k].re * fft_bins[k].re + fft_bins[k].im * fft_bins[k].im;
            lvl_0[k].idx = `FAS_BIN_IDX_W'(k);
        end
    end

    always_comb
    begin
        for (int k = 0; k < 8; k++)
        begin
            lvl_1[k] = pick(lvl_0[2*k], lvl_0[2*k+1]);
        end
        for (int k = 0; k < 4; k++)
        begin
            lvl_2[k] = pick(lvl_1[2*k], lvl_1[2*k+1]);
        end
        for (int k = 0; k < 2; k++)
        begin
            lvl_3[k] = pick(lvl_2[2*k], lvl_2[2*k+1]);
        end
        peak = pick(lvl_3[0], lvl_3[1]);
    end

    assign freq = peak.idx;

endmodule

//--- fas_top.sv
`timescale 1ns/1ps
`include "fas_defines.svh"

module fas_top (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            data_valid,
    input  logic signed [`FAS_SAMPLE_W-1:0] data,
    output logic                            fir_valid,
    output logic signed [`FAS_SAMPLE_W-1:0] fir_d,
    output logic                            fft_valid,
    output fas_pkg::cplx_t [`FAS_FFT_N-1:0] fft_bins,
    output logic [`FAS_BIN_IDX_W-1:0]       freq
);

    fir_filter u_fir_filter (
        .clk        (clk),
        .rst        (rst),
        .data_valid (data_valid),
        .data       (data),
        .fir_valid  (fir_valid),
        .fir_d      (fir_d)
    );

    fft_engine u_fft_engine (
        .clk       (clk),
        .rst       (rst),
        .fir_valid (fir_valid),
        .fir_d     (fir_d),
        .fft_valid (fft_valid),
        .fft_bins  (fft_bins)
    );

    peak_bin_finder u_peak_bin_finder (
        .fft_bins (fft_bins),
        .freq     (freq)      // Valid alongside fft_valid
    );

endmodule

//--- tb_fas_top.sv
`timescale 1ns/1ps
`include "fas_defines.svh"

module tb_fas_top;

    localparam int HALF_NS     = 50;
    localparam int N_SAMPLES   = 49;
    localparam int STIM_WORDS  = N_SAMPLES + `FAS_FFT_N + 1;
    localparam int WATCHDOG_NS = (N_SAMPLES * 4 + 8 + 20) * 2 * HALF_NS;

    logic                                  clk;
    logic                                  rst;
    logic                                  data_valid;
    logic signed [`FAS_SAMPLE_W-1:0]       data;
    logic                                  fir_valid;
    logic signed [`FAS_SAMPLE_W-1:0]       fir_d;
    logic                                  fft_valid;
    fas_pkg::cplx_t [`FAS_FFT_N-1:0]       fft_bins;
    logic [`FAS_BIN_IDX_W-1:0]             freq;

    logic [31:0]                     stim_mem [STIM_WORDS];
    logic signed [`FAS_SAMPLE_W-1:0] hist [$];   // Every accepted sample with the oldest first
    int errors;
    int accepted;
    int fir_outs;
    int fft_count;
    int cyc;
    int frame_cyc;
    bit frame_ready;
    integer seed;

    // First half of the symmetric low-pass response
    int coef_half [16] = '{-98, -122, -89, 59, 331, 586, 546, -28,
                           -1083, -2102, -2226, -652, 2842, 7596, 12190, 15017};

    fas_top u_fas_top (
        .clk        (clk),
        .rst        (rst),
        .data_valid (data_valid),
        .data       (data),
        .fir_valid  (fir_valid),
        .fir_d      (fir_d),
        .fft_valid  (fft_valid),
        .fft_bins   (fft_bins),
        .freq       (freq)
    );

    always #HALF_NS clk = ~clk;

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("mismatch %s got %h expected %h at %0t", name, got, exp, $time);
            errors++;
        end
    endtask

    // Weighted sum of the last 32 accepted samples rounded to 16 bits
    function automatic logic signed [15:0] fir_model();
        longint acc;
        logic [63:0] bits;
        int n;
        acc = 0;
        n = hist.size();
        for (int k = 0; k < `FAS_TAPS; k++)
        begin
            acc += longint'(hist[n-1-k]) * longint'(coef_half[(k < 16) ? k : 31 - k]);
        end
        bits = acc;
        return {bits[63], bits[30:16]} + {15'd0, bits[63]};
    endfunction

    // Largest energy with the first index winning a tie
    function automatic logic [3:0] strongest_bin();
        longint best;
        longint mag;
        logic signed [15:0] re;
        logic signed [15:0] im;
        logic [3:0] idx;
        best = -1;
        idx = 0;
        for (int k = 0; k < `FAS_FFT_N; k++)
        begin
            re = stim_mem[N_SAMPLES+k][31:16];
            im = stim_mem[N_SAMPLES+k][15:0];
            mag = longint'(re) * re + longint'(im) * im;
            if (mag > best)
            begin
                best = mag;
                idx = 4'(k);
            end
        end
        return idx;
    endfunction

    task automatic finish_run();
        $display("Errors: %0d, FFT pulses: %0d", errors, fft_count);
        if (errors == 0)
        begin
            $display("Finished with no errors");
        end
        else
        begin
            $display("Finished with errors");
        end
        $finish;
    endtask

    // Looks at the outputs in the middle of the low phase
    always
    begin
        @(negedge clk);
        #(HALF_NS / 2);
        cyc++;
        check("fir_valid", 32'(fir_valid), 32'(data_valid && accepted >= `FAS_WARMUP));
        if (fir_valid && data_valid && accepted >= `FAS_WARMUP)
        begin
            check("fir_d", 32'(fir_d), 32'(fir_model()));
        end
        check("fft_valid", 32'(fft_valid), 32'(frame_ready && cyc == frame_cyc + 5));
        if (fft_valid)
        begin
            fft_count++;
            for (int k = 0; k < `FAS_FFT_N; k++)
            begin
                check($sformatf("fft_bins[%0d]", k), 32'(fft_bins[k]), stim_mem[N_SAMPLES+k]);
            end
            check("freq", 32'(freq), stim_mem[N_SAMPLES+`FAS_FFT_N]);
            check("freq_model", 32'(freq), 32'(strongest_bin()));
        end
        if (data_valid && !rst)
        begin
            hist.push_back(data);
            accepted++;
            if (fir_valid)
            begin
                fir_outs++;
                if (fir_outs == `FAS_FFT_N)
                begin
                    frame_ready = 1'b1;   // This cycle's rising edge closes the frame
                    frame_cyc   = cyc;
                end
            end
        end
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("Timeout: the FFT result did not arrive within %0d ns", WATCHDOG_NS);
        errors++;
        finish_run();
    end

    initial
    begin
        int gap;
        clk = 1'b0;
        rst = 1'b1;
        data_valid = 1'b0;
        data = '0;
        errors = 0;
        accepted = 0;
        fir_outs = 0;
        fft_count = 0;
        cyc = 0;
        frame_cyc = 0;
        frame_ready = 1'b0;
        seed = 91663;
        $readmemh("fas_stim.txt", stim_mem);
        repeat (8) @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < N_SAMPLES; i++)
        begin
            gap = $unsigned($random(seed)) % 4;
            data_valid = 1'b0;
            repeat (gap) @(negedge clk);
            data_valid = 1'b1;
            data = stim_mem[i][15:0];
            @(negedge clk);
        end
        data_valid = 1'b0;
        wait (fft_count > 0);
        repeat (6) @(negedge clk);   // Any second pulse would show up here
        check("fft_pulse_count", 32'(fft_count), 32'd1);
        finish_run();
    end

endmodule

//--- fas_stim.txt
// Lines 1-49: input sample (low 16 bits), lines 50-65: expected bin {re, im},
// line 66: expected peak index
00008000
000003E8
000003E8
000003E8
000003E8
000003E8
000003E8
000003E8
000003E8
000003E8
000003E8
000003E8
000003E8
000003E8
000003E8
000003E8
000003E8
000003E8
000003E8
000003E8
000003E8
000003E8
000003E8
000003E8
000003E8
000003E8
000003E8
000003E8
000003E8
000003E8
000003E8
000003E8
000003E8
000003E8
000003E8
000003E8
000003E8
000003E8
000003E8
000003E8
000003E8
000003E8
000003E8
000003E8
000003E8
000003E8
000003E8
000003E8
00007FFF
3E700000
00000000
00000000
00000000
00000000
00000000
00000000
00000000
00000000
00000000
00000000
00000000
00000000
00000000
00000000
00000000
00000000

//--- fas_top.f
+incdir+.
fas_pkg.sv
fir_filter.sv
fft_butterfly.sv
fft_engine.sv
peak_bin_finder.sv
fas_top.sv
tb_fas_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f fas_top.f --top-module tb_fas_top -o sim_fas
./obj_dir/sim_fas > sim.log 2>&1
cat sim.log

if grep -q "Finished with errors" sim.log; then
    echo "Simulation FAILED"
    exit 1
fi
echo "Simulation PASSED"
